// ==== Makefile ====
# Verilator simulation of the SDRAM burst self-test.
VERILATOR ?= verilator
TOP       ?= tb_mem_tester
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := Finished with no errors

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, result taken from $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test PASSED"; \
	else \
		echo "test FAILED, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
+incdir+.
bus_pkg.sv
test_pkg.sv
burst_engine.sv
word_checker.sv
uart_tx.sv
mem_tester_top.sv
mem_tester_properties.sv
tb_mem_tester.sv

// ==== burst_engine.sv ====
`timescale 1ns/1ns
`include "mem_tester_macros.svh"

module burst_engine
    import bus_pkg::*, test_pkg::*;
(
    input  logic          clk_133MHz_210,
    input  logic          rst_n,
    output wb_req_t       wb_o,
    input  wb_rsp_t       wb_i,
    input  logic          halt,         // Checker saw a mismatch.
    output logic          result_valid,
    output burst_result_t result,
    input  logic          result_ready
);

    localparam int IDX_W = $clog2(`BURST_LEN);
    localparam int GAP_W = $clog2(`ROUND_GAP + 1);

    typedef enum logic [1:0] {S_BUS, S_HAND, S_GAP, S_STOP} state_t;

    state_t                                 state;
    logic [IDX_W:0]                         beat;   // MSB set in read half.
    logic [IDX_W-1:0]                       idx;    // Word within burst.
    logic [`MEM_ADDR_W-1:0]                 base;
    logic [`MEM_DATA_W-1:0]                 data;
    logic [GAP_W-1:0]                       gap_cnt;
    logic [`BURST_LEN-1:0][`MEM_DATA_W-1:0] rd_buf; // Current round, read side.
    logic                                   last_round;
    logic                                   result_free;
    logic                                   take_rd;
    logic                                   load_res;

    assign idx         = beat[IDX_W-1:0];
    assign last_round  = (base == `MEM_ADDR_W'(`TEST_WORDS - `BURST_LEN));
    assign result_free = !result_valid || result_ready; // Slot empty or leaving.
    assign take_rd     = (state == S_BUS) && wb_o.stb && wb_i.ack && beat[IDX_W];
    assign load_res    = (state == S_HAND) && result_free;

    //////////////////////////////////////////////////
    // Round sequencer and bus master.
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_BUS;
            wb_o         <= '0;
            beat         <= '0;
            base         <= '0;
            data         <= '0;
            gap_cnt      <= '0;
            result_valid <= 1'b0;
        end else begin
            if (result_valid && result_ready)
                result_valid <= 1'b0; // Checker took it.
            case (state)
                S_BUS: begin
                    if (!wb_o.stb) begin
                        // Issue next beat, writes first.
                        wb_o.cyc <= 1'b1;
                        wb_o.stb <= 1'b1;
                        wb_o.we  <= !beat[IDX_W];
                        wb_o.adr <= base + `MEM_ADDR_W'(idx);
                        wb_o.dat <= data;
                    end else if (wb_i.ack) begin
                        wb_o.stb <= 1'b0; // Single beat per transfer.
                        beat     <= beat + 1'b1;
                        if (beat == '1) begin
                            wb_o.cyc <= 1'b0;
                            state    <= S_HAND;
                        end
                    end
                end
                S_HAND: begin
                    // Wait here while the previous result is still held.
                    if (result_free) begin
                        result_valid <= 1'b1;
                        base         <= base + `MEM_ADDR_W'(`BURST_LEN);
                        data         <= data + 1'b1;
                        gap_cnt      <= '0;
                        state        <= last_round ? S_STOP : S_GAP;
                    end
                end
                S_GAP: begin
                    if (gap_cnt == GAP_W'(`ROUND_GAP - 1))
                        state <= halt ? S_STOP : S_BUS; // No new round once halted.
                    else
                        gap_cnt <= gap_cnt + 1'b1;
                end
                default: state <= S_STOP; // Sweep over.
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Read-back capture and result hold.
    always_ff @(posedge clk_133MHz_210) begin
        if (take_rd)
            rd_buf[idx] <= wb_i.dat; // Data valid in ack cycle.
        if (load_res)
            result <= '{expected: data, rd_data: rd_buf, last: last_round};
    end

endmodule

// ==== bus_pkg.sv ====
`include "mem_tester_macros.svh"

package bus_pkg;

    //////////////////////////////////////////////////
    // Wishbone classic, master side.
    typedef struct packed {
        logic                   cyc; // Bus cycle in progress.
        logic                   stb; // Transfer request.
        logic                   we;  // High for write.
        logic [`MEM_ADDR_W-1:0] adr; // Word address.
        logic [`MEM_DATA_W-1:0] dat; // Write data.
    } wb_req_t;

    //////////////////////////////////////////////////
    // Wishbone classic, slave side.
    typedef struct packed {
        logic                   ack; // One cycle per transfer.
        logic [`MEM_DATA_W-1:0] dat; // Read data, valid with ack.
    } wb_rsp_t;

endpackage

// ==== mem_tester_macros.svh ====
`ifndef MEM_TESTER_MACROS_SVH
`define MEM_TESTER_MACROS_SVH

//////////////////////////////////////////////////
// Memory bus.

// Word address, bank + row + column.
`define MEM_ADDR_W 24
// One SDRAM word.
`define MEM_DATA_W 16

//////////////////////////////////////////////////
// Test sweep.

// Words per round.
`define BURST_LEN 4
// Words under test, a multiple of BURST_LEN.
`define TEST_WORDS 32
// Idle clocks between read-back and next round.
`define ROUND_GAP 16

//////////////////////////////////////////////////
// Serial report.

// 133.33 MHz / 115200 baud.
`define BAUD_DIV 1157
// Mismatch in a high-byte slot.
`define ERR_HIGH 8'hEE
// Mismatch in a low-byte slot.
`define ERR_LOW 8'hFF

`endif

// ==== mem_tester_patterns.txt ====
// fault_addr fault_mask expect_halt, hex, one run per line.
// A zero mask leaves memory intact and the run must end with done.
00000000 00000000 0
00000005 00000100 1
0000001F 00008000 1
00000000 00000001 1
00000000 00000000 0

// ==== mem_tester_properties.sv ====
`timescale 1ns/1ns

module mem_tester_properties
    import bus_pkg::*;
(
    input logic    clk_133MHz_210,
    input logic    rst_n,
    input wb_req_t wb_o,
    input wb_rsp_t wb_i,
    input logic    led,
    input logic    done
);

    int fail_cnt = 0; // Failed properties so far.

    //////////////////////////////////////////////////
    // Wishbone master rules.
    stb_in_cycle: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        wb_o.stb |-> wb_o.cyc)
        else begin
            $error("stb high outside a bus cycle");
            fail_cnt++;
        end

    // Request held until the slave answers.
    req_stable: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        wb_o.stb && !wb_i.ack |=> wb_o.stb && $stable(wb_o.adr)
                                  && $stable(wb_o.we) && $stable(wb_o.dat))
        else begin
            $error("request changed while waiting for ack");
            fail_cnt++;
        end

    //////////////////////////////////////////////////
    // Status outputs.
    led_sticky: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        led |=> led)
        else begin
            $error("led fell before reset");
            fail_cnt++;
        end

    led_done_excl: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        !(led && done))
        else begin
            $error("led and done high together");
            fail_cnt++;
        end

endmodule

// ==== mem_tester_top.sv ====
`timescale 1ns/1ns
`include "mem_tester_macros.svh"

module mem_tester_top
    import bus_pkg::*, test_pkg::*;
(
    input  logic    clk_133MHz_210,
    input  logic    rst_n,
    output wb_req_t wb_o,
    input  wb_rsp_t wb_i,
    output logic    txd,
    output logic    led,   // Mismatch seen.
    output logic    done
);

    logic          result_valid;
    burst_result_t result;
    logic          result_ready;
    logic          byte_valid;
    report_byte_t  byte_out;
    logic          byte_ready;
    logic          halt;

    assign led = halt;

    //////////////////////////////////////////////////
    // Bus side.
    burst_engine i_engine (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .wb_o           (wb_o),
        .wb_i           (wb_i),
        .halt           (halt),
        .result_valid   (result_valid),
        .result         (result),
        .result_ready   (result_ready)
    );

    // Compare and pick report bytes.
    word_checker i_checker (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .result_valid   (result_valid),
        .result         (result),
        .result_ready   (result_ready),
        .byte_valid     (byte_valid),
        .byte_out       (byte_out),
        .byte_ready     (byte_ready),
        .halt           (halt),
        .done           (done)
    );

    // Serial side.
    uart_tx i_uart (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .byte_valid     (byte_valid),
        .byte_in        (byte_out),
        .byte_ready     (byte_ready),
        .txd            (txd)
    );

endmodule

// ==== tb_mem_tester.sv ====
`timescale 1ns/1ns
`include "mem_tester_macros.svh"

module tb_mem_tester
    import bus_pkg::*, test_pkg::*;
;

    localparam int ROUNDS     = `TEST_WORDS / `BURST_LEN;
    localparam int FRAME_CLKS = 11 * `BAUD_DIV;            // One UART frame.
    localparam int RUN_CLKS   = ROUNDS * 8 * FRAME_CLKS + 4 * FRAME_CLKS + 1000;
    localparam int MAX_RUNS   = 16;

    logic    clk_133MHz_210;
    logic    rst_n;
    wb_req_t wb_o;
    wb_rsp_t wb_i = '0;
    logic    txd;
    logic    led;
    logic    done;

    logic [31:0]            pat [0:3*MAX_RUNS-1]; // Address, mask, halt per run.
    logic [`MEM_DATA_W-1:0] mem [0:`TEST_WORDS-1];
    report_byte_t           rx_bytes[$];          // Everything seen on txd.
    report_byte_t           exp_bytes[$];
    integer                 seed = 32'h8f034d8f;
    int                     fault_adr;
    logic [`MEM_DATA_W-1:0] fault_mask;
    int                     xfer_cnt;             // Transfers since reset.
    int                     cycle_cnt = 0;
    int                     cycle_limit = 0;
    logic                   pending;
    int                     wait_cnt;
    int                     beat;
    int                     rnd;
    int                     exp_adr;

    mem_tester_top i_dut (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .wb_o           (wb_o),
        .wb_i           (wb_i),
        .txd            (txd),
        .led            (led),
        .done           (done)
    );

    bind mem_tester_top mem_tester_properties i_props (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .wb_o           (wb_o),
        .wb_i           (wb_i),
        .led            (led),
        .done           (done)
    );

    initial begin
        clk_133MHz_210 = 1'b0;
        forever #10 clk_133MHz_210 = ~clk_133MHz_210; // 20 ns period.
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    // Background word for one address.
    function automatic logic [`MEM_DATA_W-1:0] fill_word(input int a);
        return `MEM_DATA_W'((a * 32'h9E37) ^ (a >> 3) ^ 32'hA5C3);
    endfunction

    // Expected bytes. Round r writes r, sent high byte first.
    task automatic build_expected(input int fault_a, input logic [15:0] mask);
        logic [15:0] word_val;
        exp_bytes.delete();
        for (int r = 0; r < ROUNDS; r++) begin
            word_val = 16'(r);
            for (int w = 0; w < `BURST_LEN; w++) begin
                if (mask != 0 && fault_a == r * `BURST_LEN + w) begin
                    exp_bytes.push_back(`ERR_HIGH); // Tester halts here.
                    return;
                end
                exp_bytes.push_back(word_val[15:8]);
                exp_bytes.push_back(word_val[7:0]);
            end
        end
    endtask

    task automatic apply_reset();
        @(negedge clk_133MHz_210);
        rst_n = 1'b0;
        repeat (3) @(negedge clk_133MHz_210);
        assert (!wb_o.cyc) else report_failure(
            $sformatf("mismatch wb_o.cyc: got %h expected 0", wb_o.cyc));
        assert (!wb_o.stb) else report_failure(
            $sformatf("mismatch wb_o.stb: got %h expected 0", wb_o.stb));
        assert (txd) else report_failure($sformatf("mismatch txd: got %h expected 1", txd));
        assert (!led) else report_failure($sformatf("mismatch led: got %h expected 0", led));
        assert (!done) else report_failure(
            $sformatf("mismatch done: got %h expected 0", done));
        rst_n = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // Wishbone slave memory with random ack delay.
    always @(negedge clk_133MHz_210) begin
        if (!rst_n) begin
            wb_i     <= '0;
            pending  = 1'b0;
            xfer_cnt = 0;
            for (int i = 0; i < `TEST_WORDS; i++)
                mem[i] = fill_word(i);
        end else if (wb_i.ack) begin
            wb_i.ack <= 1'b0; // Single cycle ack.
        end else if (wb_o.cyc && wb_o.stb) begin
            if (!pending) begin
                pending  = 1'b1;
                wait_cnt = int'($unsigned($random(seed)) % 32'd4);
            end
            if (wait_cnt == 0) begin
                pending = 1'b0;
                beat    = xfer_cnt % 8;
                rnd     = xfer_cnt / 8;
                exp_adr = rnd * `BURST_LEN + beat % `BURST_LEN;
                assert (rnd < ROUNDS) else report_failure("bus transfer after the last round");
                assert (wb_o.we == (beat < `BURST_LEN)) else report_failure(
                    $sformatf("mismatch wb_o.we: got %h expected %h",
                              wb_o.we, beat < `BURST_LEN));
                assert (wb_o.adr == `MEM_ADDR_W'(exp_adr)) else report_failure(
                    $sformatf("mismatch wb_o.adr: got %h expected %h", wb_o.adr, exp_adr));
                if (wb_o.we) begin
                    assert (wb_o.dat == `MEM_DATA_W'(rnd)) else report_failure(
                        $sformatf("mismatch wb_o.dat: got %h expected %h", wb_o.dat, rnd));
                    mem[exp_adr] = wb_o.dat;
                    wb_i.ack    <= 1'b1;
                end else begin
                    // Injected fault on read only.
                    wb_i <= '{ack: 1'b1, dat: mem[exp_adr]
                              ^ ((exp_adr == fault_adr) ? fault_mask : '0)};
                end
                xfer_cnt = xfer_cnt + 1;
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end
    end

    //////////////////////////////////////////////////
    // UART receiver sampling mid-bit.
    initial begin : uart_rx
        report_byte_t b;
        forever begin
            @(negedge clk_133MHz_210);
            if (rst_n && !txd) begin
                repeat (`BAUD_DIV / 2) @(negedge clk_133MHz_210);
                assert (!txd) else report_failure("UART start bit did not hold");
                for (int i = 0; i < 8; i++) begin
                    repeat (`BAUD_DIV) @(negedge clk_133MHz_210);
                    b[i] = txd; // LSB first.
                end
                repeat (`BAUD_DIV) @(negedge clk_133MHz_210);
                assert (txd) else report_failure("UART first stop bit is low");
                rx_bytes.push_back(b);
                repeat (`BAUD_DIV) @(negedge clk_133MHz_210);
                assert (txd) else report_failure("UART second stop bit is low");
            end
        end
    end

    // Watchdog and bound property monitor.
    always @(posedge clk_133MHz_210) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
            report_failure($sformatf("timeout: runs not finished in %0d cycles", cycle_limit));
        assert (i_dut.i_props.fail_cnt == 0) else report_failure(
            "a bound bus or status property failed");
    end

    //////////////////////////////////////////////////
    // Run sequencer.
    initial begin : runs
        int   n_runs;
        int   rx_base;
        logic exp_halt;
        rst_n      = 1'b0;
        fault_adr  = -1;
        fault_mask = '0;
        for (int i = 0; i < 3 * MAX_RUNS; i++)
            pat[i] = '1; // End marker.
        $readmemh("mem_tester_patterns.txt", pat);
        n_runs = 0;
        while (n_runs < MAX_RUNS && pat[3*n_runs] != '1)
            n_runs++;
        assert (n_runs > 0) else report_failure("pattern file holds no runs");
        cycle_limit = n_runs * RUN_CLKS;
        for (int run = 0; run < n_runs; run++) begin
            fault_adr  = int'(pat[3*run]);
            fault_mask = pat[3*run+1][`MEM_DATA_W-1:0]; // Zero for a clean run.
            exp_halt   = pat[3*run+2][0];
            apply_reset();
            rx_base = rx_bytes.size();
            build_expected(fault_adr, fault_mask);
            while (!(done || led))
                @(negedge clk_133MHz_210);
            repeat (2 * FRAME_CLKS) @(negedge clk_133MHz_210); // Catch stray bytes.
            assert (led == exp_halt) else report_failure(
                $sformatf("mismatch led: got %h expected %h", led, exp_halt));
            assert (done == !exp_halt) else report_failure(
                $sformatf("mismatch done: got %h expected %h", done, !exp_halt));
            assert (rx_bytes.size() - rx_base == exp_bytes.size()) else report_failure(
                $sformatf("mismatch byte count: got %h expected %h",
                          rx_bytes.size() - rx_base, exp_bytes.size()));
            for (int i = 0; i < exp_bytes.size(); i++)
                assert (rx_bytes[rx_base+i] == exp_bytes[i]) else report_failure(
                    $sformatf("mismatch txd byte %0d: got %h expected %h",
                              i, rx_bytes[rx_base+i], exp_bytes[i]));
            if (!exp_halt)
                assert (xfer_cnt == ROUNDS * 8) else report_failure(
                    $sformatf("mismatch transfer count: got %h expected %h",
                              xfer_cnt, ROUNDS * 8));
        end
        if (i_dut.i_props.fail_cnt == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            report_failure("a bound bus or status property failed");
        end
    end

endmodule

// ==== test_pkg.sv ====
`include "mem_tester_macros.svh"

package test_pkg;

    //////////////////////////////////////////////////
    // One round, from engine to checker.
    typedef struct packed {
        // Word written to every address of the burst.
        logic [`MEM_DATA_W-1:0] expected;
        // Read-back words, index 0 at the base address.
        logic [`BURST_LEN-1:0][`MEM_DATA_W-1:0] rd_data;
        // Final round of the sweep.
        logic last;
    } burst_result_t;

    //////////////////////////////////////////////////
    // One byte, from checker to UART.
    typedef logic [7:0] report_byte_t;

endpackage

// ==== uart_tx.sv ====
`timescale 1ns/1ns
`include "mem_tester_macros.svh"

module uart_tx
    import test_pkg::*;
(
    input  logic         clk_133MHz_210,
    input  logic         rst_n,
    input  logic         byte_valid,
    input  report_byte_t byte_in,
    output logic         byte_ready,
    output logic         txd
);

    localparam int FRAME_BITS = 11; // Start, 8 data, 2 stop.
    localparam int BAUD_W     = $clog2(`BAUD_DIV);

    logic                  busy;
    logic [FRAME_BITS-1:0] frame;    // Shifts out LSB first.
    logic [3:0]            bit_cnt;
    logic [BAUD_W-1:0]     baud_cnt;

    assign byte_ready = !busy;
    assign txd        = frame[0]; // All ones when idle.

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            frame    <= '1;
            bit_cnt  <= '0;
            baud_cnt <= '0;
        end else if (!busy) begin
            if (byte_valid) begin
                busy     <= 1'b1;
                frame    <= {2'b11, byte_in, 1'b0};
                bit_cnt  <= '0;
                baud_cnt <= '0;
            end
        end else if (baud_cnt == BAUD_W'(`BAUD_DIV - 1)) begin
            baud_cnt <= '0;
            frame    <= {1'b1, frame[FRAME_BITS-1:1]}; // Ones fill in behind.
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 4'(FRAME_BITS - 1))
                busy <= 1'b0; // Last stop bit ends here.
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

// ==== word_checker.sv ====
`timescale 1ns/1ns
`include "mem_tester_macros.svh"

module word_checker
    import test_pkg::*;
(
    input  logic          clk_133MHz_210,
    input  logic          rst_n,
    input  logic          result_valid,
    input  burst_result_t result,
    output logic          result_ready,
    output logic          byte_valid,
    output report_byte_t  byte_out,
    input  logic          byte_ready,
    output logic          halt,         // Sticky until reset.
    output logic          done
);

    localparam int IDX_W = $clog2(`BURST_LEN);

    typedef enum logic [2:0] {C_IDLE, C_SEND, C_DRAIN, C_DONE, C_HALT} state_t;

    state_t                 state;
    burst_result_t          res_q;  // Round under report.
    logic [IDX_W:0]         slot;   // LSB picks the low byte.
    logic [`MEM_DATA_W-1:0] word;
    logic                   match;

    assign word  = res_q.rd_data[slot[IDX_W:1]];
    assign match = (word == res_q.expected);

    // High byte first, error code in place of a bad byte.
    assign byte_out = match ? (slot[0] ? word[7:0] : word[`MEM_DATA_W-1 -: 8])
                            : (slot[0] ? `ERR_LOW : `ERR_HIGH);

    assign result_ready = (state == C_IDLE);
    assign byte_valid   = (state == C_SEND);
    assign halt         = (state == C_HALT);
    assign done         = (state == C_DONE);

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state <= C_IDLE;
            slot  <= '0;
        end else begin
            case (state)
                C_IDLE: begin
                    if (result_valid) begin
                        slot  <= '0;
                        state <= C_SEND; // First byte offered next cycle.
                    end
                end
                C_SEND: begin
                    if (byte_ready) begin
                        if (!match)
                            state <= C_HALT; // Error byte went out, stop here.
                        else if (slot == '1)
                            state <= res_q.last ? C_DRAIN : C_IDLE;
                        else
                            slot <= slot + 1'b1;
                    end
                end
                C_DRAIN: begin
                    // UART is busy right after the transfer; idle again means sent.
                    if (byte_ready)
                        state <= C_DONE;
                end
                default: state <= state; // Done or halted, hold.
            endcase
        end
    end

    // Payload copy, taken on handshake.
    always_ff @(posedge clk_133MHz_210) begin
        if (result_valid && result_ready)
            res_q <= result;
    end

endmodule
